// File: bench/aes_controller_assert.sv
// Bound concurrent assertions on reset values, four-phase handshakes and read-port stalls
`timescale 1ns/1ps

module aes_controller_assert (
	input logic                            clk,
	input logic                            reset,
	input logic                            busy,
	input logic                            core_req,
	input aes_bus_pkg::core_req_t          core_req_data,
	input logic                            core_ack,
	input logic                            res_req,
	input logic                            res_ack,
	input logic                            rd_valid,
	input logic                            rd_ready,
	input logic [aes_ctrl_pkg::WORD_S-1:0] rd_data,
	input logic                            rd_last
);
	// Number of failed properties so far
	int err_count = 0;

	// Outputs quiet in the first cycle out of reset
	assert property (@(posedge clk) $past(reset) && !reset |->
		!busy && !core_req && !res_ack && !rd_valid)
	else begin
		err_count++;
		$error("busy, core_req, res_ack or rd_valid high right after reset");
	end

	// Request held until acked, then dropped and kept low while ack is up
	assert property (@(posedge clk) disable iff (reset) core_req && !core_ack |=> core_req)
	else begin
		err_count++;
		$error("core_req dropped before core_ack");
	end

	assert property (@(posedge clk) disable iff (reset) core_ack |=> !core_req)
	else begin
		err_count++;
		$error("core_req high on the cycle after core_ack");
	end

	// Request payload frozen across the whole handshake
	assert property (@(posedge clk) disable iff (reset)
		(core_req || core_ack) && $past(core_req || core_ack) |-> $stable(core_req_data))
	else begin
		err_count++;
		$error("core_req_data changed during the core handshake");
	end

	// Ack follows the result request one cycle later, both ways
	assert property (@(posedge clk) disable iff (reset)
		res_ack || !res_req |=> res_ack == $past(res_req))
	else begin
		err_count++;
		$error("res_ack out of four-phase order");
	end

	assert property (@(posedge clk) disable iff (reset)
		rd_valid && !rd_ready |=> rd_valid && $stable(rd_data) && $stable(rd_last))
	else begin
		err_count++;
		$error("Read word not held while rd_ready was low");
	end

endmodule

// File: bench/aes_controller_tb.sv
// Testbench with clock, reset, LCG stimulus, keyed core model, read scoreboard and watchdog
`timescale 1ns/1ps

module aes_controller_tb;
	import aes_ctrl_pkg::*;
	import aes_bus_pkg::*;

	localparam int NUM_MSGS = 12;
	// Worst case of 40 cycles for each word of a command and four blocks
	localparam int TIMEOUT_CYCLES = NUM_MSGS * (1 + 4 * NB) * 40;

	typedef struct packed {
		logic              last;
		logic [WORD_S-1:0] data;
	} rd_word_t;

	logic              clk;
	logic              reset = 1'b1;
	logic              bus_wren;
	logic              bus_tlast;
	logic              busy;
	logic [WORD_S-1:0] bus_data;
	logic [WORD_S-1:0] rd_data;
	logic              core_req;
	logic              core_ack;
	logic              res_req;
	logic              res_ack;
	logic              rd_valid;
	logic              rd_ready;
	logic              rd_last;
	core_req_t         core_req_data;
	core_res_t         res_data;
	logic [31:0]       rng_state = 32'hbbd0_bae7;
	logic [BLK_S-1:0]  key_exp;
	logic [BLK_S-1:0]  core_key;
	core_req_t         exp_req[$];
	rd_word_t          exp_rd[$];

	// Small queues so both FIFOs run full
	aes_controller #(.IN_FIFO_DEPTH(4), .IN_FIFO_ADDR_WIDTH(2),
		.OUT_FIFO_DEPTH(2), .OUT_FIFO_ADDR_WIDTH(1)) u_dut (.*);

	bind aes_controller aes_controller_assert u_assert (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Taken from the upper bits where the LCG period is long
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_random();
		return int'(r[30:16]) % n;
	endfunction

	task automatic next_edge(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic send_word(input logic [WORD_S-1:0] data, input logic tlast,
		input logic ends_entry);
		while (busy)
			next_edge(1);
		bus_wren = 1'b1;
		bus_data = data;
		bus_tlast = tlast;
		next_edge(1);
		bus_wren = 1'b0;
		bus_tlast = 1'b0;
		// Queue write pending after a command word or the last word of a block
		assert (!ends_entry || busy)
		else stop_with_failure($sformatf("[ERROR] %0t: busy low after a complete queue entry",
			$time));
		if (rand_below(4) == 0)
			next_edge(1);
	endtask

	initial begin : stimulus
		int                nblk;
		aes_opcode_e       op;
		logic [WORD_S-1:0] cmd;
		logic [BLK_S-1:0]  blk;
		core_req_t         er;
		rd_word_t          ew;
		bus_wren = 1'b0;
		bus_tlast = 1'b0;
		bus_data = '0;
		key_exp = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int m = 0; m < NUM_MSGS; m++) begin
			nblk = 1 + rand_below(4);
			// First message loads a key
			case ((m == 0) ? 0 : rand_below(3))
				0: op = CMD_SET_KEY;
				1: op = CMD_ENCRYPT;
				default: op = CMD_DECRYPT;
			endcase
			cmd = next_random();
			cmd[OPC_W-1:0] = op;
			send_word(cmd, 1'b0, 1'b1);
			for (int b = 0; b < nblk; b++) begin
				for (int w = 0; w < NB; w++)
					blk[w*WORD_S +: WORD_S] = next_random();
				er.op = op;
				er.blk = blk;
				er.last = (b == nblk - 1);
				exp_req.push_back(er);
				if (op == CMD_SET_KEY)
					key_exp = blk;
				for (int w = 0; w < NB; w++) begin
					ew.data = blk[w*WORD_S +: WORD_S] ^ key_exp[w*WORD_S +: WORD_S];
					ew.last = er.last && (w == NB - 1);
					if (op != CMD_SET_KEY)
						exp_rd.push_back(ew);
					send_word(blk[w*WORD_S +: WORD_S], ew.last, w == NB - 1);
				end
			end
		end
		while (exp_req.size() != 0 || exp_rd.size() != 0)
			next_edge(1);
		// Idle tail where a stray request or read word would still show up
		next_edge(20);
		if (u_dut.u_assert.err_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			stop_with_failure("A bound handshake assertion failed");
		end
	end

	// Keyed stand-in for the cipher core
	initial begin : core_model
		core_req_t got;
		core_req_t want;
		core_ack = 1'b0;
		res_req = 1'b0;
		res_data = '0;
		core_key = '0;
		forever begin
			next_edge(1);
			if (core_req) begin
				got = core_req_data;
				assert (exp_req.size() != 0)
				else stop_with_failure($sformatf("[ERROR] %0t: unexpected core request %h",
					$time, got.blk));
				want = exp_req.pop_front();
				assert (got == want)
				else stop_with_failure($sformatf(
					"[ERROR] %0t: request op %0d last %0b blk %h, expected op %0d last %0b blk %h",
					$time, got.op, got.last, got.blk, want.op, want.last, want.blk));
				next_edge(1 + rand_below(4));
				core_ack = 1'b1;
				while (core_req)
					next_edge(1);
				next_edge(1 + rand_below(3));
				core_ack = 1'b0;
				if (got.op == CMD_SET_KEY) begin
					core_key = got.blk;
				end else begin
					res_data.blk = got.blk ^ core_key;
					res_data.last = got.last;
					res_req = 1'b1;
					while (!res_ack)
						next_edge(1);
					res_req = 1'b0;
					while (res_ack)
						next_edge(1);
				end
			end
		end
	end

	// Random rd_ready with a word moving at the next edge when both are high
	initial begin : reader
		rd_word_t want;
		rd_ready = 1'b0;
		forever begin
			next_edge(1);
			rd_ready = (rand_below(4) != 0);
			if (rd_valid && rd_ready) begin
				assert (exp_rd.size() != 0)
				else stop_with_failure($sformatf("[ERROR] %0t: unexpected read word %h",
					$time, rd_data));
				want = exp_rd.pop_front();
				assert (rd_data == want.data && rd_last == want.last)
				else stop_with_failure($sformatf(
					"[ERROR] %0t: read word %h last %0b, expected %h last %0b",
					$time, rd_data, rd_last, want.data, want.last));
			end
		end
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		stop_with_failure("Timeout: the message stream did not complete in time");
	end

	always @(posedge clk) begin
		if (u_dut.u_assert.err_count != 0)
			stop_with_failure("A bound handshake assertion failed");
	end

endmodule

// File: rtl/aes_bus_pkg.sv
// Packed structs for queue entries and core request and result payloads
package aes_bus_pkg;

	// One input queue entry, a command word or a payload block
	typedef struct packed {
		logic                            last;
		logic [aes_ctrl_pkg::BLK_S-1:0]  blk;
	} queue_entry_t;

	// Request to the cipher core
	typedef struct packed {
		aes_ctrl_pkg::aes_opcode_e       op;
		logic [aes_ctrl_pkg::BLK_S-1:0]  blk;
		logic                            last;
	} core_req_t;

	// Result from the cipher core
	typedef struct packed {
		logic [aes_ctrl_pkg::BLK_S-1:0]  blk;
		logic                            last;
	} core_res_t;

	// Entry widths used to size the two FIFOs
	localparam int QUEUE_ENTRY_W = $bits(queue_entry_t);
	localparam int CORE_RES_W = $bits(core_res_t);

endpackage

// File: rtl/aes_controller.sv
// AES controller top level joining the input, dispatch and output blocks
`timescale 1ns/1ps

module aes_controller #(
	parameter int IN_FIFO_DEPTH = 16,
	parameter int IN_FIFO_ADDR_WIDTH = 4,
	parameter int OUT_FIFO_DEPTH = 16,
	parameter int OUT_FIFO_ADDR_WIDTH = 4
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            bus_wren,
	input  logic                            bus_tlast,
	input  logic [aes_ctrl_pkg::WORD_S-1:0] bus_data,
	output logic                            busy,
	output logic                            core_req,
	output aes_bus_pkg::core_req_t          core_req_data,
	input  logic                            core_ack,
	input  logic                            res_req,
	input  aes_bus_pkg::core_res_t          res_data,
	output logic                            res_ack,
	output logic                            rd_valid,
	input  logic                            rd_ready,
	output logic [aes_ctrl_pkg::WORD_S-1:0] rd_data,
	output logic                            rd_last
);
	import aes_bus_pkg::*;

	// Input queue read side
	logic         q_valid;
	logic         q_ready;
	queue_entry_t q_data;

	aes_controller_input #(
		.FIFO_DEPTH(IN_FIFO_DEPTH),
		.FIFO_ADDR_WIDTH(IN_FIFO_ADDR_WIDTH)
	) u_input (
		.clk(clk),
		.reset(reset),
		.bus_wren(bus_wren),
		.bus_tlast(bus_tlast),
		.bus_data(bus_data),
		.busy(busy),
		.q_valid(q_valid),
		.q_ready(q_ready),
		.q_data(q_data)
	);

	aes_controller_dispatch u_dispatch (
		.clk(clk),
		.reset(reset),
		.q_valid(q_valid),
		.q_ready(q_ready),
		.q_data(q_data),
		.core_req(core_req),
		.core_req_data(core_req_data),
		.core_ack(core_ack)
	);

	aes_controller_output #(
		.FIFO_DEPTH(OUT_FIFO_DEPTH),
		.FIFO_ADDR_WIDTH(OUT_FIFO_ADDR_WIDTH)
	) u_output (
		.clk(clk),
		.reset(reset),
		.res_req(res_req),
		.res_data(res_data),
		.res_ack(res_ack),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.rd_data(rd_data),
		.rd_last(rd_last)
	);

endmodule

// File: rtl/aes_controller_dispatch.sv
// Dispatcher: command decode, queue pop and the four-phase core request channel
`timescale 1ns/1ps

module aes_controller_dispatch (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      q_valid,
	output logic                      q_ready,
	input  aes_bus_pkg::queue_entry_t q_data,
	output logic                      core_req,
	output aes_bus_pkg::core_req_t    core_req_data,
	input  logic                      core_ack
);
	import aes_ctrl_pkg::*;

	disp_state_e state;
	aes_opcode_e opcode;
	logic        pop;

	// One entry at a time, never during a handshake
	assign q_ready = (state == WAIT_CMD) || (state == WAIT_BLK);
	assign pop = q_valid && q_ready;

	// Request is up exactly while waiting for the ack
	assign core_req = (state == REQ_HIGH);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= WAIT_CMD;
		end else begin
			case (state)
				WAIT_CMD: begin
					if (q_valid)
						state <= WAIT_BLK;
				end
				WAIT_BLK: begin
					if (q_valid)
						state <= REQ_HIGH;
				end
				REQ_HIGH: begin
					if (core_ack)
						state <= REQ_LOW;
				end
				REQ_LOW: begin
					// Core has dropped ack, next block or next command
					if (!core_ack)
						state <= core_req_data.last ? WAIT_CMD : WAIT_BLK;
				end
				default: state <= WAIT_CMD;
			endcase
		end
	end

	// Opcode of the current message, upper command bits ignored
	always_ff @(posedge clk) begin
		if (pop && (state == WAIT_CMD))
			opcode <= aes_opcode_e'(q_data.blk[OPC_W-1:0]);
	end

	// Held from request rise through ack fall
	always_ff @(posedge clk) begin
		if (pop && (state == WAIT_BLK)) begin
			core_req_data.op <= opcode;
			core_req_data.blk <= q_data.blk;
			core_req_data.last <= q_data.last;
		end
	end

endmodule

// File: rtl/aes_controller_input.sv
// Input block: command and payload word capture, block packing and the input queue
`timescale 1ns/1ps

module aes_controller_input #(
	parameter int FIFO_DEPTH = 16,
	parameter int FIFO_ADDR_WIDTH = 4
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            bus_wren,
	input  logic                            bus_tlast,
	input  logic [aes_ctrl_pkg::WORD_S-1:0] bus_data,
	output logic                            busy,
	output logic                            q_valid,
	input  logic                            q_ready,
	output aes_bus_pkg::queue_entry_t       q_data
);
	import aes_ctrl_pkg::*;
	import aes_bus_pkg::*;

	localparam logic [NB_W-1:0] LAST_WORD = NB_W'(NB - 1);

	in_state_e       state;
	logic [NB_W-1:0] word_cnt;
	logic            accept;
	logic            cmd_done;
	logic            blk_done;
	logic            wr_valid;
	logic            wr_ready;
	logic            full;
	queue_entry_t    wr_entry;

	// A word is taken only while nothing is waiting for the queue
	assign busy = wr_valid || full;
	assign accept = bus_wren && !busy;
	assign cmd_done = accept && (state == GET_CMD);
	assign blk_done = accept && (state == GET_PAYLOAD) && (word_cnt == LAST_WORD);

	// Framing of command word and payload blocks
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= GET_CMD;
			word_cnt <= '0;
		end else if (accept) begin
			if (state == GET_CMD) begin
				state <= GET_PAYLOAD;
				word_cnt <= '0;
			end else begin
				word_cnt <= word_cnt + 1'b1;
				if (blk_done && bus_tlast)
					state <= GET_CMD;
			end
		end
	end

	// Newest word lands in the top word, so word 0 ends in bits 31:0
	always_ff @(posedge clk) begin
		if (accept) begin
			if (state == GET_CMD) begin
				wr_entry.last <= 1'b0;
				wr_entry.blk <= {{(BLK_S - WORD_S){1'b0}}, bus_data};
			end else begin
				wr_entry.last <= bus_tlast;
				wr_entry.blk <= {bus_data, wr_entry.blk[BLK_S-1:WORD_S]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			wr_valid <= 1'b0;
		else if (cmd_done || blk_done)
			wr_valid <= 1'b1;
		else if (wr_valid && wr_ready)
			wr_valid <= 1'b0;
	end

	fifo #(
		.DEPTH(FIFO_DEPTH),
		.ADDR_WIDTH(FIFO_ADDR_WIDTH),
		.DATA_WIDTH(QUEUE_ENTRY_W)
	) u_in_fifo (
		.clk(clk),
		.reset(reset),
		.wr_valid(wr_valid),
		.wr_ready(wr_ready),
		.wr_data(wr_entry),
		.rd_ready(q_ready),
		.rd_valid(q_valid),
		.rd_data(q_data),
		.almost_full(),
		.full(full),
		.empty()
	);

endmodule

// File: rtl/aes_controller_output.sv
// Output block: result handshake into the output queue and 32-bit read serializer
`timescale 1ns/1ps

module aes_controller_output #(
	parameter int FIFO_DEPTH = 16,
	parameter int FIFO_ADDR_WIDTH = 4
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            res_req,
	input  aes_bus_pkg::core_res_t          res_data,
	output logic                            res_ack,
	output logic                            rd_valid,
	input  logic                            rd_ready,
	output logic [aes_ctrl_pkg::WORD_S-1:0] rd_data,
	output logic                            rd_last
);
	import aes_ctrl_pkg::*;
	import aes_bus_pkg::*;

	localparam logic [NB_W-1:0] LAST_WORD = NB_W'(NB - 1);

	core_res_t       head;
	logic [NB_W-1:0] word_idx;
	logic            push;
	logic            room;
	logic            word_xfer;
	logic            pop;

	// New result offered until it is acked
	assign push = res_req && !res_ack;

	always_ff @(posedge clk) begin
		if (reset)
			res_ack <= 1'b0;
		else if (push && room)
			res_ack <= 1'b1;
		else if (res_ack && !res_req)
			res_ack <= 1'b0;
	end

	// Serializer walks the head entry word by word
	assign word_xfer = rd_valid && rd_ready;
	assign pop = word_xfer && (word_idx == LAST_WORD);
	assign rd_data = head.blk[word_idx*WORD_S +: WORD_S];
	assign rd_last = head.last && (word_idx == LAST_WORD);

	// Wraps to word 0 together with the pop
	always_ff @(posedge clk) begin
		if (reset)
			word_idx <= '0;
		else if (word_xfer)
			word_idx <= word_idx + 1'b1;
	end

	fifo #(
		.DEPTH(FIFO_DEPTH),
		.ADDR_WIDTH(FIFO_ADDR_WIDTH),
		.DATA_WIDTH(CORE_RES_W)
	) u_out_fifo (
		.clk(clk),
		.reset(reset),
		.wr_valid(push),
		.wr_ready(room),
		.wr_data(res_data),
		.rd_ready(pop),
		.rd_valid(rd_valid),
		.rd_data(head),
		.almost_full(),
		.full(),
		.empty()
	);

endmodule

// File: rtl/aes_ctrl_pkg.sv
// Controller sizing constants, command opcodes and FSM state encodings
package aes_ctrl_pkg;

	// Bus word and AES block sizes
	localparam int WORD_S = 32;
	localparam int BLK_S = 128;

	// Words per block and the width of a counter over them
	localparam int NB = BLK_S / WORD_S;
	localparam int NB_W = $clog2(NB);

	// Opcode field in the low bits of the command word
	localparam int OPC_W = 2;

	typedef enum logic [OPC_W-1:0] {
		CMD_SET_KEY = 2'd0,
		CMD_ENCRYPT = 2'd1,
		CMD_DECRYPT = 2'd2
	} aes_opcode_e;

	// Input block framing
	typedef enum logic {
		GET_CMD,
		GET_PAYLOAD
	} in_state_e;

	// Dispatcher, two pop states then the request handshake
	typedef enum logic [1:0] {
		WAIT_CMD,
		WAIT_BLK,
		REQ_HIGH,
		REQ_LOW
	} disp_state_e;

endpackage

// File: rtl/fifo.sv
// Synchronous valid/ready FIFO with occupancy count and full, almost-full, empty flags
`timescale 1ns/1ps

module fifo #(
	parameter int DEPTH = 16,
	parameter int ADDR_WIDTH = 4,
	parameter int DATA_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wr_valid,
	output logic                  wr_ready,
	input  logic [DATA_WIDTH-1:0] wr_data,
	input  logic                  rd_ready,
	output logic                  rd_valid,
	output logic [DATA_WIDTH-1:0] rd_data,
	output logic                  almost_full,
	output logic                  full,
	output logic                  empty
);
	localparam logic [ADDR_WIDTH:0] COUNT_MAX = (ADDR_WIDTH + 1)'(DEPTH);
	localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(DEPTH - 1);

	logic [DATA_WIDTH-1:0] mem [DEPTH];
	logic [ADDR_WIDTH-1:0] wr_ptr;
	logic [ADDR_WIDTH-1:0] rd_ptr;
	logic [ADDR_WIDTH:0]   count;
	logic                  do_write;
	logic                  do_read;

	assign do_write = wr_valid && wr_ready;
	assign do_read = rd_valid && rd_ready;

	// Status flags straight from the occupancy count
	assign full = (count == COUNT_MAX);
	assign almost_full = (count == COUNT_MAX - 1'b1);
	assign empty = (count == '0);
	assign wr_ready = !full;
	assign rd_valid = !empty;

	// Head entry is shown without a read stage
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write)
				wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;

			// Simultaneous push and pop leave the count alone
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= wr_data;
	end

endmodule

// File: run.sh
#!/bin/sh
# Build the AES controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module aes_controller_tb -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vaes_controller_tb +verilator+error+limit+100
if [ $? -ne 0 ]; then
	echo "Simulation failed"
	exit 1
fi
exit 0

// File: sim.f
rtl/aes_ctrl_pkg.sv
rtl/aes_bus_pkg.sv
rtl/fifo.sv
rtl/aes_controller_input.sv
rtl/aes_controller_dispatch.sv
rtl/aes_controller_output.sv
rtl/aes_controller.sv
bench/aes_controller_assert.sv
bench/aes_controller_tb.sv
